//--- cdc_pkg.sv
`default_nettype none

package cdc_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry

	// Byte address on the AXI side, 64 word indexes
	localparam int addr_w = 8;
	localparam int data_w = 32;
	// One strobe bit per data byte
	localparam int strb_w = data_w / 8;

	//////////////////////////////////////////////////////////////////////
	// Register bank layout

	// Implemented word indexes, the rest decode as errors
	localparam int reg_count = 16;
	// Read-only count of completed writes
	localparam int counter_index = 15;

	//////////////////////////////////////////////////////////////////////
	// Response codes and crossing depth

	localparam logic [1:0] resp_okay = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;
	// Flops on the receiving side of each flag synchronizer
	localparam int sync_stages = 2;

endpackage

`default_nettype wire

//--- bit_sync.sv
`timescale 1ns/1ps
`default_nettype none

module bit_sync (
	input wire clk_in,
	input wire din,
	input wire clk_out,
	output logic dout
);

	// Launch flop in the sending domain
	logic din_q;
	// Capture chain in the receiving domain
	logic [cdc_pkg::sync_stages-1:0] chain;

	// Register the flag first so no combinational glitch crosses
	always_ff @(posedge clk_in) begin
		din_q <= din;
	end

	// Shift through the metastability chain
	always_ff @(posedge clk_out) begin
		chain <= {chain[cdc_pkg::sync_stages-2:0], din_q};
	end

	// Oldest stage is the settled value
	assign dout = chain[cdc_pkg::sync_stages-1];

endmodule

`default_nettype wire

//--- handshake_sync.sv
`timescale 1ns/1ps
`default_nettype none

module handshake_sync (
	input wire clk_a,
	input wire rst,
	input wire en_a,
	output logic ack_a,
	input wire clk_b,
	input wire rst_b,
	output logic en_b,
	input wire ack_b
);

	//////////////////////////////////////////////////////////////////////
	// Flag crossings

	// Request flag, owned by the clk_a side
	logic req_flag;
	logic req_sync;
	// Acknowledge flag, owned by the clk_b side
	logic ack_flag;
	logic ack_sync;

	// Control state per side
	logic [1:0] state_a;
	logic [1:0] state_b;

	bit_sync req_sync_i (
		.clk_in(clk_a),
		.din(req_flag),
		.clk_out(clk_b),
		.dout(req_sync)
	);

	bit_sync ack_sync_i (
		.clk_in(clk_b),
		.din(ack_flag),
		.clk_out(clk_a),
		.dout(ack_sync)
	);

	//////////////////////////////////////////////////////////////////////
	// Sender on clk_a

	always_ff @(posedge clk_a) begin
		if (rst) begin
			state_a <= 2'd0;
			req_flag <= 1'b0;
			ack_a <= 1'b0;
		end else begin
			// Completion is a single-cycle pulse
			ack_a <= 1'b0;
			case (state_a)
				// Idle until the requester starts a transfer
				2'd0: begin
					if (en_a) begin
						req_flag <= 1'b1;
						state_a <= 2'd1;
					end
				end
				// Request raised, wait for the far side to take it
				2'd1: begin
					if (ack_sync) begin
						req_flag <= 1'b0;
						state_a <= 2'd2;
					end
				end
				// Receiver is finished once its flag drops again
				2'd2: begin
					if (!ack_sync) begin
						ack_a <= 1'b1;
						state_a <= 2'd0;
					end
				end
				default: begin
					state_a <= 2'd0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Receiver on clk_b

	always_ff @(posedge clk_b) begin
		if (rst_b) begin
			state_b <= 2'd0;
			ack_flag <= 1'b0;
			en_b <= 1'b0;
		end else begin
			en_b <= 1'b0;
			case (state_b)
				// Wait for a synchronized request
				2'd0: begin
					if (req_sync) begin
						en_b <= 1'b1;
						state_b <= 2'd1;
					end
				end
				// Completer is working on the buffer
				2'd1: begin
					if (ack_b) begin
						ack_flag <= 1'b1;
						state_b <= 2'd2;
					end
				end
				// Hold the acknowledge until the request is released
				2'd2: begin
					if (!req_sync) begin
						ack_flag <= 1'b0;
						state_b <= 2'd0;
					end
				end
				default: begin
					state_b <= 2'd0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface xfer_if;

	// Request half, written on clk_a while no handshake is open
	logic write;
	logic [cdc_pkg::addr_w-1:0] addr;
	logic [cdc_pkg::data_w-1:0] wdata;
	logic [cdc_pkg::strb_w-1:0] wstrb;

	// Response half, written on clk_b between en_b and ack_b
	logic [cdc_pkg::data_w-1:0] rdata;
	logic [1:0] resp;

	// AXI side fills the request and reads back the result
	modport requester (
		output write,
		output addr,
		output wdata,
		output wstrb,
		input rdata,
		input resp
	);

	// Register side consumes the request and posts the result
	modport completer (
		input write,
		input addr,
		input wdata,
		input wstrb,
		output rdata,
		output resp
	);

endinterface

`default_nettype wire

//--- axil_cdc_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_cdc_slave (
	input wire clk_a,
	input wire rst,
	// Write address and data
	input wire awvalid,
	output logic awready,
	input wire [cdc_pkg::addr_w-1:0] awaddr,
	input wire wvalid,
	output logic wready,
	input wire [cdc_pkg::data_w-1:0] wdata,
	input wire [cdc_pkg::strb_w-1:0] wstrb,
	// Write response
	output logic bvalid,
	input wire bready,
	output logic [1:0] bresp,
	// Read address and data
	input wire arvalid,
	output logic arready,
	input wire [cdc_pkg::addr_w-1:0] araddr,
	output logic rvalid,
	input wire rready,
	output logic [cdc_pkg::data_w-1:0] rdata,
	output logic [1:0] rresp,
	// Crossing handshake
	output logic en_a,
	input wire ack_a,
	xfer_if.requester xfer
);

	// 0 idle, 1 issue, 2 wait for ack_a, 3 respond
	logic [1:0] state;
	logic wr_accept;
	logic rd_accept;

	//////////////////////////////////////////////////////////////////////
	// Acceptance

	// Write needs both channels at once
	assign wr_accept = (state == 2'd0) && awvalid && wvalid;
	// Read only goes when no write is on offer
	assign rd_accept = (state == 2'd0) && arvalid && !awvalid && !wvalid;

	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk_a) begin
		if (rst) begin
			state <= 2'd0;
			en_a <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			en_a <= 1'b0;
			case (state)
				// Buffer is loaded on the accepting edge
				2'd0: begin
					if (wr_accept || rd_accept) begin
						state <= 2'd1;
					end
				end
				// Start the crossing one edge later
				2'd1: begin
					en_a <= 1'b1;
					state <= 2'd2;
				end
				// Response buffer is stable once ack_a arrives
				2'd2: begin
					if (ack_a) begin
						bvalid <= xfer.write;
						rvalid <= !xfer.write;
						state <= 2'd3;
					end
				end
				// Hold the response until the master takes it
				2'd3: begin
					if ((bvalid && bready) || (rvalid && rready)) begin
						bvalid <= 1'b0;
						rvalid <= 1'b0;
						state <= 2'd0;
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request buffer and response capture

	always_ff @(posedge clk_a) begin
		if (wr_accept) begin
			xfer.write <= 1'b1;
			xfer.addr <= awaddr;
			xfer.wdata <= wdata;
			xfer.wstrb <= wstrb;
		end else if (rd_accept) begin
			xfer.write <= 1'b0;
			xfer.addr <= araddr;
			// No byte lanes on a read
			xfer.wstrb <= '0;
		end
		// Both channels sample the result, only one gets a valid
		if ((state == 2'd2) && ack_a) begin
			bresp <= xfer.resp;
			rresp <= xfer.resp;
			rdata <= xfer.rdata;
		end
	end

endmodule

`default_nettype wire

//--- reg_bank_b.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank_b (
	input wire clk_b,
	input wire rst_b,
	input wire en_b,
	output logic ack_b,
	xfer_if.completer xfer
);

	// Entry counter_index holds the write count
	logic [cdc_pkg::data_w-1:0] regs [0:cdc_pkg::reg_count-1];

	logic [cdc_pkg::addr_w-3:0] word_index;
	logic [$clog2(cdc_pkg::reg_count)-1:0] reg_sel;
	logic in_range;
	logic is_counter;
	logic wr_ok;

	//////////////////////////////////////////////////////////////////////
	// Address decode

	// Byte address to word index
	assign word_index = xfer.addr[cdc_pkg::addr_w-1:2];
	assign reg_sel = word_index[$clog2(cdc_pkg::reg_count)-1:0];
	// Upper index bits must be clear
	assign in_range =
		(word_index[cdc_pkg::addr_w-3:$clog2(cdc_pkg::reg_count)] == '0);
	assign is_counter =
		(reg_sel == ($clog2(cdc_pkg::reg_count))'(cdc_pkg::counter_index));
	// Counter is read-only
	assign wr_ok = xfer.write && in_range && !is_counter;

	//////////////////////////////////////////////////////////////////////
	// Register storage

	always_ff @(posedge clk_b) begin
		if (rst_b) begin
			for (int i = 0; i < cdc_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
			ack_b <= 1'b0;
		end else begin
			// Done on the edge after the request appears
			ack_b <= en_b;
			if (en_b && wr_ok) begin
				// Merge enabled byte lanes into the old value
				for (int b = 0; b < cdc_pkg::strb_w; b++) begin
					if (xfer.wstrb[b]) begin
						regs[reg_sel][8*b +: 8] <= xfer.wdata[8*b +: 8];
					end
				end
				regs[cdc_pkg::counter_index] <= regs[cdc_pkg::counter_index] +
					{{(cdc_pkg::data_w-1){1'b0}}, 1'b1};
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response buffer

	always_ff @(posedge clk_b) begin
		if (en_b) begin
			if (xfer.write) begin
				xfer.rdata <= '0;
				xfer.resp <= wr_ok ? cdc_pkg::resp_okay : cdc_pkg::resp_slverr;
			end else if (in_range) begin
				xfer.rdata <= regs[reg_sel];
				xfer.resp <= cdc_pkg::resp_okay;
			end else begin
				// Unmapped read returns zero
				xfer.rdata <= '0;
				xfer.resp <= cdc_pkg::resp_slverr;
			end
		end
	end

endmodule

`default_nettype wire

//--- cdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_top (
	input wire clk_a,
	input wire clk_b,
	input wire rst,
	// AXI4-Lite slave port on clk_a
	input wire awvalid,
	output logic awready,
	input wire [cdc_pkg::addr_w-1:0] awaddr,
	input wire wvalid,
	output logic wready,
	input wire [cdc_pkg::data_w-1:0] wdata,
	input wire [cdc_pkg::strb_w-1:0] wstrb,
	output logic bvalid,
	input wire bready,
	output logic [1:0] bresp,
	input wire arvalid,
	output logic arready,
	input wire [cdc_pkg::addr_w-1:0] araddr,
	output logic rvalid,
	input wire rready,
	output logic [cdc_pkg::data_w-1:0] rdata,
	output logic [1:0] rresp
);

	// Reset as seen in the clk_b domain
	logic rst_b;
	// Handshake pulses
	logic en_a;
	logic ack_a;
	logic en_b;
	logic ack_b;

	// Shared request/response buffer
	xfer_if xfer ();

	bit_sync rst_sync_i (
		.clk_in(clk_a),
		.din(rst),
		.clk_out(clk_b),
		.dout(rst_b)
	);

	handshake_sync handshake_i (
		.clk_a(clk_a),
		.rst(rst),
		.en_a(en_a),
		.ack_a(ack_a),
		.clk_b(clk_b),
		.rst_b(rst_b),
		.en_b(en_b),
		.ack_b(ack_b)
	);

	axil_cdc_slave slave_i (
		.clk_a(clk_a),
		.rst(rst),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.en_a(en_a),
		.ack_a(ack_a),
		.xfer(xfer.requester)
	);

	reg_bank_b bank_i (
		.clk_b(clk_b),
		.rst_b(rst_b),
		.en_b(en_b),
		.ack_b(ack_b),
		.xfer(xfer.completer)
	);

endmodule

`default_nettype wire

//--- cdc_top_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_top_assertions (
	input wire clk_a,
	input wire rst,
	input wire awready,
	input wire wready,
	input wire arready,
	input wire bvalid,
	input wire bready,
	input wire [1:0] bresp,
	input wire rvalid,
	input wire rready,
	input wire [cdc_pkg::data_w-1:0] rdata,
	input wire [1:0] rresp,
	input wire en_a,
	input wire ack_a
);

	// Failed checks so far
	int failures = 0;
	// A crossing is open from en_a until its ack_a
	logic xfer_open;

	always_ff @(posedge clk_a) begin
		if (rst) begin
			xfer_open <= 1'b0;
		end else if (en_a) begin
			xfer_open <= 1'b1;
		end else if (ack_a) begin
			xfer_open <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response channels hold until taken

	bresp_held: assert property (@(posedge clk_a) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		$error("bvalid dropped or bresp changed before bready");
		failures++;
	end

	rdata_held: assert property (@(posedge clk_a) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		$error("rvalid dropped or read payload changed before rready");
		failures++;
	end

	//////////////////////////////////////////////////////////////////////
	// Acceptance and crossing order

	// Accept only when idle and never take a write and a read together
	one_accept: assert property (@(posedge clk_a) disable iff (rst)
		(awready || arready) |->
			!(awready && arready) && !xfer_open && !bvalid && !rvalid)
	else begin
		$error("ready raised while busy or awready and arready high together");
		failures++;
	end

	single_xfer: assert property (@(posedge clk_a) disable iff (rst)
		en_a |-> !xfer_open)
	else begin
		$error("en_a pulsed again before ack_a");
		failures++;
	end

	// Quiet outputs while in reset
	ready_in_reset: assert property (@(posedge clk_a)
		rst |-> !awready && !wready && !arready)
	else begin
		$error("ready output high during reset");
		failures++;
	end

	valid_in_reset: assert property (@(posedge clk_a) rst |=> !bvalid && !rvalid)
	else begin
		$error("response valid high during reset");
		failures++;
	end

endmodule

bind cdc_top cdc_top_assertions assertions_i (
	.clk_a(clk_a),
	.rst(rst),
	.awready(awready),
	.wready(wready),
	.arready(arready),
	.bvalid(bvalid),
	.bready(bready),
	.bresp(bresp),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.rresp(rresp),
	.en_a(en_a),
	.ack_a(ack_a)
);

`default_nettype wire

//--- tb_cdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_top;

	// Six hex fields per pattern line
	localparam int fields = 6;
	localparam int max_lines = 64;
	localparam int timeout_cycles = 200;

	logic clk_a;
	logic clk_b;
	logic rst;
	logic awvalid;
	logic awready;
	logic [cdc_pkg::addr_w-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [cdc_pkg::data_w-1:0] wdata;
	logic [cdc_pkg::strb_w-1:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [cdc_pkg::addr_w-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [cdc_pkg::data_w-1:0] rdata;
	logic [1:0] rresp;

	logic [31:0] patterns [0:fields*max_lines-1];
	logic [31:0] lfsr;
	// Handshakes seen on aw/w, ar, b and r in that order
	int hs_count [0:3] = '{0, 0, 0, 0};
	logic [1:0] got_bresp;
	logic [1:0] got_rresp;
	logic [cdc_pkg::data_w-1:0] got_rdata;
	int mismatches;
	int failures;
	int assert_fails;

	// Two unrelated clocks of 10 ns and 14 ns period
	initial clk_a = 1'b0;
	always #5 clk_a = ~clk_a;
	initial clk_b = 1'b0;
	always #7 clk_b = ~clk_b;

	cdc_top dut_i (
		.clk_a(clk_a),
		.clk_b(clk_b),
		.rst(rst),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.wstrb(wstrb),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	//////////////////////////////////////////////////////////////////////
	// Handshake monitor

	// Counts move on the rising edge and are read back at the falling edge
	always @(posedge clk_a) begin
		if (awvalid && awready && wvalid && wready) begin
			hs_count[0] <= hs_count[0] + 1;
		end
		if (arvalid && arready) begin
			hs_count[1] <= hs_count[1] + 1;
		end
		if (bvalid && bready) begin
			hs_count[2] <= hs_count[2] + 1;
			got_bresp <= bresp;
		end
		if (rvalid && rready) begin
			hs_count[3] <= hs_count[3] + 1;
			got_rdata <= rdata;
			got_rresp <= rresp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and compare tasks

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One step per bit taken
	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			value = (value << 1) + int'(lfsr[0]);
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_data(input logic [cdc_pkg::data_w-1:0] got,
			input logic [cdc_pkg::data_w-1:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bounded waits

	// Channel 0 is aw/w, 1 is ar, 2 is b and 3 is r
	task automatic wait_handshake(input int ch, input int start, input string what);
		int cycles;
		cycles = 0;
		while (hs_count[ch] == start && cycles < timeout_cycles) begin
			@(negedge clk_a);
			cycles++;
		end
		if (hs_count[ch] == start) begin
			$display("Timeout at %0t: no %s handshake within %0d cycles",
				$time, what, timeout_cycles);
			failures++;
		end
	endtask

	task automatic wait_response(input logic is_write);
		int cycles;
		cycles = 0;
		while (!(is_write ? bvalid : rvalid) && cycles < timeout_cycles) begin
			@(negedge clk_a);
			cycles++;
		end
		if (!(is_write ? bvalid : rvalid)) begin
			$display("Timeout at %0t: response valid never rose", $time);
			failures++;
		end
	endtask

	// rst_b lives on clk_b, so look at it on the clk_b falling edge
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (dut_i.rst_b !== 1'b0 && cycles < timeout_cycles) begin
			@(negedge clk_b);
			cycles++;
		end
		if (dut_i.rst_b !== 1'b0) begin
			$display("Timeout at %0t: reset never left the clk_b domain", $time);
			failures++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite transactions

	task automatic write_txn(input logic [cdc_pkg::addr_w-1:0] addr,
			input logic [cdc_pkg::data_w-1:0] data,
			input logic [cdc_pkg::strb_w-1:0] strb, input logic [1:0] exp_resp);
		int lead;
		int stall;
		int start;
		take_bits(1, lead);
		take_bits(2, stall);
		start = hs_count[0];
		awvalid = 1'b1;
		awaddr = addr;
		// Address sometimes runs a cycle ahead of the data
		if (lead != 0) begin
			@(negedge clk_a);
		end
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		wait_handshake(0, start, "write address and data");
		awvalid = 1'b0;
		wvalid = 1'b0;
		wait_response(1'b1);
		// Back-pressure on B
		repeat (stall) @(negedge clk_a);
		start = hs_count[2];
		bready = 1'b1;
		wait_handshake(2, start, "write response");
		bready = 1'b0;
		check_resp(got_bresp, exp_resp, $sformatf("bresp at 0x%h", addr));
	endtask

	task automatic read_txn(input logic [cdc_pkg::addr_w-1:0] addr,
			input logic [cdc_pkg::data_w-1:0] exp_data, input logic [1:0] exp_resp);
		int stall;
		int start;
		take_bits(2, stall);
		start = hs_count[1];
		arvalid = 1'b1;
		araddr = addr;
		wait_handshake(1, start, "read address");
		arvalid = 1'b0;
		wait_response(1'b0);
		// Back-pressure on R
		repeat (stall) @(negedge clk_a);
		start = hs_count[3];
		rready = 1'b1;
		wait_handshake(3, start, "read data");
		rready = 1'b0;
		check_data(got_rdata, exp_data, $sformatf("rdata at 0x%h", addr));
		check_resp(got_rresp, exp_resp, $sformatf("rresp at 0x%h", addr));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int line;
		int gap;
		int base;
		rst = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		lfsr = 32'hc7b1ab4d;
		mismatches = 0;
		failures = 0;
		assert_fails = 0;
		// Fill above any op code marks the end of the pattern list
		for (int i = 0; i < fields*max_lines; i++) begin
			patterns[i] = {16'hffff, 16'(i)};
		end
		$readmemh("cdc_patterns.txt", patterns);
		repeat (5) @(posedge clk_a);
		@(negedge clk_a);
		rst = 1'b0;
		wait_reset_release();
		line = 0;
		while (line < max_lines && patterns[line*fields] <= 32'd1) begin
			base = line * fields;
			// Idle gap before each transaction
			take_bits(2, gap);
			repeat (gap + 1) @(negedge clk_a);
			if (patterns[base] == 32'd1) begin
				write_txn(patterns[base+1][cdc_pkg::addr_w-1:0],
					patterns[base+2][cdc_pkg::data_w-1:0],
					patterns[base+3][cdc_pkg::strb_w-1:0], patterns[base+5][1:0]);
			end else begin
				read_txn(patterns[base+1][cdc_pkg::addr_w-1:0],
					patterns[base+4][cdc_pkg::data_w-1:0], patterns[base+5][1:0]);
			end
			line++;
		end
		if (line == 0) begin
			$display("No transactions could be read from cdc_patterns.txt");
			failures++;
		end
		repeat (3) @(negedge clk_a);
		assert_fails = dut_i.assertions_i.failures;
		$display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, assert_fails);
		if (mismatches + failures + assert_fails == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cdc_patterns.txt
// op addr wdata wstrb exp_rdata exp_resp, all hex
// op 0 is a read and 1 a write; exp_rdata is only checked on reads
0 00 00000000 0 00000000 0
0 1c 00000000 0 00000000 0
0 38 00000000 0 00000000 0
0 3c 00000000 0 00000000 0
1 00 deadbeef f 00000000 0
0 00 00000000 0 deadbeef 0
1 00 11223344 5 00000000 0
0 00 00000000 0 de22be44 0
1 38 a5a5a5a5 f 00000000 0
1 38 00ff00ff a 00000000 0
0 38 00000000 0 00a500a5 0
0 3c 00000000 0 00000004 0
1 3c 12345678 f 00000000 2
0 3c 00000000 0 00000004 0
1 40 cafef00d f 00000000 2
0 40 00000000 0 00000000 2
1 fc 00000001 f 00000000 2
0 fc 00000000 0 00000000 2
0 00 00000000 0 de22be44 0
1 04 0000ff00 2 00000000 0
1 04 12345678 0 00000000 0
0 04 00000000 0 0000ff00 0
0 3c 00000000 0 00000006 0

//--- verilog.f
cdc_pkg.sv
bit_sync.sv
handshake_sync.sv
xfer_if.sv
axil_cdc_slave.sv
reg_bank_b.sv
cdc_top.sv
cdc_top_assertions.sv
tb_cdc_top.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cdc_top -f verilog.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
